// ==== nes_bus_pkg.sv ====
package nes_bus_pkg;

	// NTSC master clock division
	localparam int cpu_div_n = 12;  // Master clocks per CPU cycle
	localparam int ppu_div_n = 4;   // Master clocks per PPU cycle
	localparam int cpu_cnt_w = $clog2(cpu_div_n + 1);
	localparam int ppu_cnt_w = $clog2(ppu_div_n + 1);

	// Fixed bus addresses
	localparam logic [15:0] oam_dma_addr = 16'h4014;   // Write here starts sprite DMA
	localparam logic [15:0] oam_data_addr = 16'h2004;  // Sprite DMA target
	localparam logic [15:0] ppu_base = 16'h2000;       // Start of register space
	localparam logic [15:0] apu_end = 16'h4018;        // First address past register space

	localparam int sprite_bytes = 256;  // Bytes per sprite DMA
	localparam int mem_addr_w = 22;     // External memory address width

	// Sprite DMA states
	// Bit 1 set means the transfer owns or skips the current slot
	typedef enum logic [1:0] {
		spr_idle = 2'b00,
		spr_pending = 2'b01,  // Waiting for a CPU read on an odd cycle
		spr_active = 2'b11,   // Even read, odd write
		spr_resume = 2'b10    // Odd cycle lost to a DMC fetch
	} spr_state_t;

	// DMC sample fetch states
	typedef enum logic {
		dmc_idle = 1'b0,
		dmc_armed = 1'b1  // Fetch runs on the next even cycle
	} dmc_state_t;

	// Bus request straight from the CPU
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] data;
		logic rnw;  // 1 = read
	} cpu_bus_t;

	// System bus after CPU/DMA selection
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] data;
		logic read;
		logic write;
	} sys_bus_t;

	// PRG or CHR memory request
	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic [7:0] data;
		logic read;
		logic write;
	} mem_req_t;

	// External memory port
	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic [7:0] dout;
		logic read_cpu;  // Result goes to the CPU latch
		logic read_ppu;  // Result goes to the PPU latch
		logic write;
	} mem_port_t;

endpackage

// ==== clock_divider.sv ====
`timescale 1ns/1ps

module clock_divider import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	output logic cpu_ce,
	output logic ppu_ce,
	output logic cart_window,
	output logic odd_cycle
);

	// Master cycle layout, NTSC
	// Cyc 123456789ABC
	// CPU -----------C
	// PPU ---P---P---P
	logic [cpu_cnt_w-1:0] cpu_cnt;  // Runs 1..cpu_div_n
	logic [ppu_cnt_w-1:0] ppu_cnt;  // Runs 1..ppu_div_n

	assign cpu_ce = (cpu_cnt == cpu_cnt_w'(cpu_div_n));  // Last master clock of the CPU cycle
	assign ppu_ce = (ppu_cnt == ppu_cnt_w'(ppu_div_n));

	// Cart access window, first PPU slot of each CPU cycle
	assign cart_window = (cpu_cnt >= cpu_cnt_w'(1)) && (cpu_cnt <= cpu_cnt_w'(ppu_div_n));

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_cnt <= cpu_cnt_w'(1);
			ppu_cnt <= ppu_cnt_w'(1);
			odd_cycle <= 1'b0;  // First CPU cycle is even
		end else begin
			// Wrap back to 1 on the enable clock
			if (cpu_ce) begin
				cpu_cnt <= cpu_cnt_w'(1);
			end else begin
				cpu_cnt <= cpu_cnt + 1'b1;
			end

			if (ppu_ce) begin
				ppu_cnt <= ppu_cnt_w'(1);
			end else begin
				ppu_cnt <= ppu_cnt + 1'b1;
			end

			// APU style get/put phase
			if (cpu_ce) begin
				odd_cycle <= ~odd_cycle;
			end
		end
	end

endmodule

// ==== dma_controller.sv ====
`timescale 1ns/1ps

module dma_controller import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic odd_cycle,        // Parity of the current CPU cycle
	input logic sprite_trigger,   // Write to oam_dma_addr seen on the bus
	input logic cpu_read,         // CPU sits in a read cycle
	input logic [7:0] sprite_page,
	input logic [7:0] data_from_ram,
	input logic dmc_trigger,      // Held until dmc_ack
	input logic [15:0] dmc_addr,
	output sys_bus_t dma_bus,
	output logic dma_enable,      // DMA owns the system bus
	output logic dmc_ack,
	output logic pause_cpu
);

	spr_state_t spr_state;
	dmc_state_t dmc_state;
	logic [7:0] spr_page;                         // High byte of the source
	logic [$clog2(sprite_bytes)-1:0] spr_idx;     // Low byte of the source
	logic [$clog2(sprite_bytes):0] idx_inc;       // Index plus one, top bit is the carry
	logic [7:0] spr_latch;                        // Byte read on the last even slot

	assign idx_inc = {1'b0, spr_idx} + 1'b1;

	// DMC fetch takes the even slot it was armed for
	assign dmc_ack = (dmc_state == dmc_armed) && !odd_cycle;
	assign dma_enable = dmc_ack || (spr_state == spr_active);

	// CPU stays halted while anything is queued or running
	assign pause_cpu = (spr_state != spr_idle) || dmc_trigger || (dmc_state == dmc_armed);

	always_comb begin
		if (dmc_ack) begin
			dma_bus.addr = dmc_addr;
		end else if (odd_cycle) begin
			dma_bus.addr = oam_data_addr;  // Odd slot writes OAMDATA
		end else begin
			dma_bus.addr = {spr_page, spr_idx};
		end
		dma_bus.data = spr_latch;
		dma_bus.read = dma_enable && !odd_cycle;  // Reads even, writes odd
		dma_bus.write = dma_enable && odd_cycle;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= spr_idle;
			dmc_state <= dmc_idle;
			spr_idx <= '0;
		end else if (cpu_ce) begin
			// DMC arms only on an even read cycle
			case (dmc_state)
				dmc_idle: begin
					if (dmc_trigger && cpu_read && !odd_cycle) begin
						dmc_state <= dmc_armed;
					end
				end
				dmc_armed: begin
					if (!odd_cycle) begin
						dmc_state <= dmc_idle;  // Fetch done this cycle
					end
				end
				default: dmc_state <= dmc_idle;
			endcase

			if (sprite_trigger) begin
				spr_state <= spr_pending;
				spr_idx <= '0;
			end else begin
				case (spr_state)
					spr_pending: begin
						// Start so that the first slot is even
						if (cpu_read && odd_cycle) begin
							spr_state <= spr_active;
						end
					end
					spr_active: begin
						if (dmc_ack) begin
							spr_state <= spr_resume;  // Even slot lost, skip the odd one
						end else if (odd_cycle) begin
							spr_idx <= idx_inc[$clog2(sprite_bytes)-1:0];
							if (idx_inc[$clog2(sprite_bytes)]) begin
								spr_state <= spr_idle;  // 256th write done
							end
						end
					end
					spr_resume: spr_state <= spr_active;  // Same index again
					default: spr_state <= spr_idle;
				endcase
			end
		end
	end

	// Payload, no reset needed
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger) begin
				spr_page <= sprite_page;
			end
			if ((spr_state == spr_active) && !odd_cycle && !dmc_ack) begin
				spr_latch <= data_from_ram;  // Sprite byte for the next odd slot
			end
		end
	end

endmodule

// ==== memory_multiplex.sv ====
`timescale 1ns/1ps

module memory_multiplex import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input logic ppu_ce,
	input mem_req_t prg_req,
	input mem_req_t chr_req,
	output mem_port_t mem
);

	// PPU wins the port, PRG waits for an idle PPU slot
	logic chr_busy;
	logic saved_prg_read;   // PRG read held back by CHR traffic
	logic saved_prg_write;  // PRG write held back by CHR traffic

	assign chr_busy = chr_req.read || chr_req.write;

	always_comb begin
		if (chr_busy) begin
			mem.addr = chr_req.addr;
			mem.write = chr_req.write;
		end else begin
			mem.addr = prg_req.addr;
			mem.write = prg_req.write || (saved_prg_write && ppu_ce);  // Held write goes on a PPU slot
		end
		mem.read_ppu = chr_req.read;
		mem.read_cpu = !chr_busy && (prg_req.read || (saved_prg_read && ppu_ce));
		mem.dout = chr_req.write ? chr_req.data : prg_req.data;  // Write data follows the owner
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			saved_prg_read <= 1'b0;
			saved_prg_write <= 1'b0;
		end else if (ppu_ce) begin
			if (chr_busy) begin
				// Collect PRG requests while CHR holds the port
				saved_prg_read <= prg_req.read || saved_prg_read;
				saved_prg_write <= prg_req.write || saved_prg_write;
			end else begin
				// Port was free this slot, held access went out
				saved_prg_read <= 1'b0;
				saved_prg_write <= 1'b0;
			end
		end
	end

endmodule

// ==== nes_bus_core.sv ====
`timescale 1ns/1ps

module nes_bus_core import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input cpu_bus_t cpu,               // Request from the external CPU
	input logic dmc_trigger,
	input logic [15:0] dmc_addr,
	input mem_req_t chr_req,           // PPU pattern fetches
	input logic [7:0] memory_din_cpu,  // Memory data for the CPU side
	output logic cpu_ce,
	output logic ppu_ce,
	output logic odd_cycle,
	output logic pause_cpu,
	output logic dmc_ack,
	output sys_bus_t sys_bus,
	output mem_port_t mem
);

	logic cart_window;
	logic dma_enable;
	logic sprite_trigger;
	logic prg_range;   // Address outside PPU/APU register space
	sys_bus_t dma_bus;
	mem_req_t prg_req;

	clock_divider u_clock_divider (
		.clk(clk),
		.reset(reset),
		.cpu_ce(cpu_ce),
		.ppu_ce(ppu_ce),
		.cart_window(cart_window),
		.odd_cycle(odd_cycle)
	);

	// Bus owner: DMA when it asks, else the CPU
	always_comb begin
		if (dma_enable) begin
			sys_bus = dma_bus;
		end else begin
			sys_bus.addr = cpu.addr;
			sys_bus.data = cpu.data;
			sys_bus.read = cpu.rnw;
			sys_bus.write = !cpu.rnw;
		end
	end

	assign sprite_trigger = sys_bus.write && (sys_bus.addr == oam_dma_addr);

	dma_controller u_dma_controller (
		.clk(clk),
		.reset(reset),
		.cpu_ce(cpu_ce),
		.odd_cycle(odd_cycle),
		.sprite_trigger(sprite_trigger),
		.cpu_read(cpu.rnw),
		.sprite_page(sys_bus.data),       // Page byte written to OAMDMA
		.data_from_ram(memory_din_cpu),
		.dmc_trigger(dmc_trigger),
		.dmc_addr(dmc_addr),
		.dma_bus(dma_bus),
		.dma_enable(dma_enable),
		.dmc_ack(dmc_ack),
		.pause_cpu(pause_cpu)
	);

	// Registers at 0x2000..0x4017 never reach memory
	assign prg_range = (sys_bus.addr < ppu_base) || (sys_bus.addr >= apu_end);

	always_comb begin
		prg_req.addr = {{(mem_addr_w - 16){1'b0}}, sys_bus.addr};
		prg_req.data = sys_bus.data;
		prg_req.read = sys_bus.read && prg_range && cart_window;  // Only in the cart slot
		prg_req.write = sys_bus.write && prg_range && cart_window;
	end

	memory_multiplex u_memory_multiplex (
		.clk(clk),
		.reset(reset),
		.ppu_ce(ppu_ce),
		.prg_req(prg_req),
		.chr_req(chr_req),
		.mem(mem)
	);

endmodule

// ==== nes_bus_model.svh ====
`ifndef NES_BUS_MODEL_SVH
`define NES_BUS_MODEL_SVH

// Divider model state
typedef struct packed {
	logic [7:0] cpu_cnt;
	logic [7:0] ppu_cnt;
	logic odd;
} div_model_t;

// DMA model state
typedef struct packed {
	spr_state_t spr;
	dmc_state_t dmc;
	logic [7:0] page;
	logic [7:0] idx;
	logic [7:0] latch;
} dma_model_t;

// Held PRG flags of the multiplexer
typedef struct packed {
	logic saved_read;
	logic saved_write;
} mem_model_t;

task automatic model_div_reset(output div_model_t s);
	s.cpu_cnt = 8'd1;
	s.ppu_cnt = 8'd1;
	s.odd = 1'b0;
endtask

// Enables seen before the next clock edge
task automatic model_div_eval(input div_model_t s, output logic cpu_ce, output logic ppu_ce,
		output logic cart_window);
	cpu_ce = (s.cpu_cnt == cpu_div_n);
	ppu_ce = (s.ppu_cnt == ppu_div_n);
	cart_window = (s.cpu_cnt >= 1) && (s.cpu_cnt <= ppu_div_n);
endtask

task automatic model_div_step(inout div_model_t s);
	if (s.cpu_cnt == cpu_div_n) begin
		s.cpu_cnt = 8'd1;
		s.odd = ~s.odd;  // Parity flips with each CPU cycle
	end else begin
		s.cpu_cnt = s.cpu_cnt + 8'd1;
	end
	s.ppu_cnt = (s.ppu_cnt == ppu_div_n) ? 8'd1 : s.ppu_cnt + 8'd1;
endtask

task automatic model_dma_eval(input dma_model_t s, input logic odd, input logic dmc_trigger,
		input logic [15:0] dmc_addr, output sys_bus_t bus, output logic enable,
		output logic ack, output logic pause);
	ack = (s.dmc == dmc_armed) && !odd;
	enable = ack || (s.spr == spr_active);
	pause = (s.spr != spr_idle) || dmc_trigger || (s.dmc == dmc_armed);
	bus.addr = ack ? dmc_addr : (odd ? oam_data_addr : {s.page, s.idx});
	bus.data = s.latch;
	bus.read = enable && !odd;
	bus.write = enable && odd;
endtask

// Call on cpu_ce only, odd is the parity of the ending cycle
task automatic model_dma_step(input logic sprite_trigger, input logic [7:0] page_in,
		input logic cpu_read, input logic [7:0] din, input logic dmc_trigger,
		input logic odd, inout dma_model_t s);
	dma_model_t n;
	logic ack;
	n = s;
	ack = (s.dmc == dmc_armed) && !odd;
	if (s.dmc == dmc_idle && dmc_trigger && cpu_read && !odd) begin
		n.dmc = dmc_armed;
	end else if (ack) begin
		n.dmc = dmc_idle;
	end
	if (sprite_trigger) begin
		n.spr = spr_pending;
		n.page = page_in;
		n.idx = 8'd0;
	end else if (s.spr == spr_pending && cpu_read && odd) begin
		n.spr = spr_active;
	end else if (s.spr == spr_active && ack) begin
		n.spr = spr_resume;  // Odd slot idles next
	end else if (s.spr == spr_active && odd) begin
		n.idx = s.idx + 8'd1;
		if (s.idx == 8'hff) begin
			n.spr = spr_idle;
		end
	end else if (s.spr == spr_resume) begin
		n.spr = spr_active;
	end
	if (s.spr == spr_active && !odd && !ack) begin
		n.latch = din;
	end
	s = n;
endtask

// Held access only goes out on a PPU slot with CHR idle
task automatic model_mem_eval(input mem_model_t s, input mem_req_t prg, input mem_req_t chr,
		input logic ppu_slot, output mem_port_t m);
	logic busy;
	busy = chr.read || chr.write;
	m.addr = busy ? chr.addr : prg.addr;
	m.write = busy ? chr.write : (prg.write || (s.saved_write && ppu_slot));
	m.read_ppu = chr.read;
	m.read_cpu = !busy && (prg.read || (s.saved_read && ppu_slot));
	m.dout = chr.write ? chr.data : prg.data;
endtask

// Call on ppu_ce only
task automatic model_mem_step(input mem_req_t prg, input mem_req_t chr, inout mem_model_t s);
	if (chr.read || chr.write) begin
		s.saved_read = s.saved_read || prg.read;
		s.saved_write = s.saved_write || prg.write;
	end else begin
		s.saved_read = 1'b0;
		s.saved_write = 1'b0;
	end
endtask

`endif

// ==== tb_nes_bus_core.sv ====
`timescale 1ns/1ps

module tb_nes_bus_core import nes_bus_pkg::*; ();

	`include "nes_bus_model.svh"

	localparam int idle_len = 600;                // Clocks of plain CPU traffic
	localparam int chr_len = 800;                 // Clocks of CPU traffic against CHR fetches
	localparam int spr_len = 520 * cpu_div_n;     // Clocks per sprite DMA
	localparam int cycle_limit = 2 * (idle_len + chr_len + 2 * spr_len);

	logic clk;
	logic reset;
	cpu_bus_t cpu;
	logic dmc_trigger;
	logic [15:0] dmc_addr;
	mem_req_t chr_req;
	logic [7:0] memory_din_cpu;
	logic cpu_ce;
	logic ppu_ce;
	logic odd_cycle;
	logic pause_cpu;
	logic dmc_ack;
	sys_bus_t sys_bus;
	mem_port_t mem;

	integer seed;
	int error_count = 0;
	int cycle_count = 0;
	int since;                // Clocks since reset release
	div_model_t dv;
	dma_model_t dm;
	mem_model_t mm;
	logic chr_traffic;        // Random CHR fetches on
	logic track_sprite;       // Sprite transfer scoreboard on
	logic [7:0] spr_page_tb;
	logic [7:0] spr_idx_tb;
	logic [7:0] spr_byte;     // Byte the DMA should write next
	int dma_reads;
	int dma_writes;
	int ack_count;
	logic last_cpu_ce = 1'b0;
	logic last_ack = 1'b0;
	logic last_pause = 1'b0;

	nes_bus_core uut (
		.clk(clk),
		.reset(reset),
		.cpu(cpu),
		.dmc_trigger(dmc_trigger),
		.dmc_addr(dmc_addr),
		.chr_req(chr_req),
		.memory_din_cpu(memory_din_cpu),
		.cpu_ce(cpu_ce),
		.ppu_ce(ppu_ce),
		.odd_cycle(odd_cycle),
		.pause_cpu(pause_cpu),
		.dmc_ack(dmc_ack),
		.sys_bus(sys_bus),
		.mem(mem)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run did not finish within %0d clock cycles", cycle_limit);
			$display("FAIL: see errors above");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic stop_on_error(input string what);
		error_count++;
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
				$time, name, exp, act));
		end
	endtask

	task automatic check_bus(input string name, input sys_bus_t exp, input sys_bus_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_mem(input string name, input mem_port_t exp, input mem_port_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, exp, act));
		end
	endtask

	// One master clock, called right after a falling edge with cpu already driven
	task automatic run_cycle();
		logic e_cpu_ce;
		logic e_ppu_ce;
		logic e_cart;
		logic e_enable;
		logic e_ack;
		logic e_pause;
		logic e_trig;
		logic in_prg;
		sys_bus_t e_dma;
		sys_bus_t e_sys;
		sys_bus_t spr_exp;
		mem_req_t e_prg;
		mem_port_t e_mem;
		memory_din_cpu = 8'($random(seed));
		if (chr_traffic) begin
			chr_req.addr = mem_addr_w'($random(seed));
			chr_req.data = 8'($random(seed));
			chr_req.read = (($random(seed) & 3) == 0);
			chr_req.write = !chr_req.read && (($random(seed) & 7) == 0);
		end else begin
			chr_req = '0;
		end
		#1;
		model_div_eval(dv, e_cpu_ce, e_ppu_ce, e_cart);
		model_dma_eval(dm, dv.odd, dmc_trigger, dmc_addr, e_dma, e_enable, e_ack, e_pause);
		if (e_enable) begin
			e_sys = e_dma;  // DMA owns the bus
		end else begin
			e_sys.addr = cpu.addr;
			e_sys.data = cpu.data;
			e_sys.read = cpu.rnw;
			e_sys.write = !cpu.rnw;
		end
		e_trig = e_sys.write && (e_sys.addr == oam_dma_addr);
		in_prg = (e_sys.addr < ppu_base) || (e_sys.addr >= apu_end);
		e_prg.addr = mem_addr_w'(e_sys.addr);  // Zero extended
		e_prg.data = e_sys.data;
		e_prg.read = e_sys.read && in_prg && e_cart;
		e_prg.write = e_sys.write && in_prg && e_cart;
		model_mem_eval(mm, e_prg, chr_req, e_ppu_ce, e_mem);

		// Enable pattern straight from the divider ratios
		check_bit("cpu_ce", (since % cpu_div_n) == cpu_div_n - 1, cpu_ce);
		check_bit("ppu_ce", (since % ppu_div_n) == ppu_div_n - 1, ppu_ce);
		check_bit("odd_cycle", dv.odd, odd_cycle);
		check_bit("pause_cpu", e_pause, pause_cpu);
		check_bit("dmc_ack", e_ack, dmc_ack);
		check_bus("sys_bus", e_sys, sys_bus);
		check_mem("mem", e_mem, mem);

		if (track_sprite && e_enable && !e_ack) begin
			spr_exp.addr = dv.odd ? oam_data_addr : {spr_page_tb, spr_idx_tb};
			spr_exp.data = spr_byte;
			spr_exp.read = !dv.odd;  // Even read, odd write
			spr_exp.write = dv.odd;
			check_bus("sys_bus", spr_exp, sys_bus);
		end

		@(posedge clk);
		if (e_cpu_ce) begin
			model_dma_step(e_trig, e_sys.data, cpu.rnw, memory_din_cpu, dmc_trigger, dv.odd, dm);
			if (track_sprite && e_enable && !e_ack) begin
				if (!dv.odd) begin
					spr_byte = memory_din_cpu;  // Latched for the odd write
					dma_reads++;
				end else begin
					spr_idx_tb = spr_idx_tb + 8'd1;
					dma_writes++;
				end
			end
			if (e_ack) begin
				ack_count++;
			end
		end
		if (e_ppu_ce) begin
			model_mem_step(e_prg, chr_req, mm);
		end
		model_div_step(dv);
		last_cpu_ce = e_cpu_ce;
		last_ack = e_ack;
		last_pause = e_pause;
		since++;
		@(negedge clk);
	endtask

	task automatic random_traffic(input int n);
		repeat (n) begin
			cpu.addr = 16'($random(seed));
			cpu.data = 8'($random(seed));
			cpu.rnw = 1'($random(seed));
			if (!cpu.rnw && cpu.addr == oam_dma_addr) begin
				cpu.rnw = 1'b1;  // No sprite DMA here
			end
			run_cycle();
		end
	endtask

	task automatic sprite_dma(input logic with_dmc);
		int dmc_at;
		int clocks;
		logic dmc_sent;
		spr_page_tb = 8'($random(seed));
		spr_idx_tb = 8'd0;
		dma_reads = 0;
		dma_writes = 0;
		ack_count = 0;
		dmc_sent = 1'b0;
		dmc_at = 200 + ($random(seed) & 4095);  // Lands mid transfer
		dmc_addr = 16'hc000 | 16'($random(seed));
		chr_traffic = with_dmc;
		track_sprite = 1'b1;
		// CPU write to OAMDMA held through a CPU cycle end
		cpu.addr = oam_dma_addr;
		cpu.data = spr_page_tb;
		cpu.rnw = 1'b0;
		do begin
			run_cycle();
		end while (!last_cpu_ce);
		cpu.rnw = 1'b1;  // Stalled CPU keeps reading
		clocks = 0;
		do begin
			cpu.addr = 16'h8000 | 16'($random(seed));
			if (with_dmc && !dmc_sent && clocks == dmc_at) begin
				dmc_trigger = 1'b1;
				dmc_sent = 1'b1;
			end
			run_cycle();
			if (last_cpu_ce && last_ack) begin
				dmc_trigger = 1'b0;  // Requester lets go after the ack
			end
			clocks++;
		end while (last_pause);
		track_sprite = 1'b0;
		if (dma_reads != sprite_bytes || dma_writes != sprite_bytes) begin
			stop_on_error($sformatf("Sprite DMA made %0d reads and %0d writes, not %0d each",
				dma_reads, dma_writes, sprite_bytes));
		end
		if (with_dmc && ack_count != 1) begin
			stop_on_error($sformatf("DMC fetch during sprite DMA gave %0d ack cycles, not one",
				ack_count));
		end
	endtask

	initial begin
		seed = 61663;
		reset = 1'b1;
		cpu = '{addr: 16'h0000, data: 8'h00, rnw: 1'b1};
		dmc_trigger = 1'b0;
		dmc_addr = 16'h0000;
		chr_req = '0;
		memory_din_cpu = 8'h00;
		chr_traffic = 1'b0;
		track_sprite = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		model_div_reset(dv);
		dm.spr = spr_idle;
		dm.dmc = dmc_idle;
		dm.idx = 8'd0;
		mm = '0;
		since = 0;

		random_traffic(idle_len);   // Enables and CPU pass-through
		chr_traffic = 1'b1;
		random_traffic(chr_len);    // PPU priority and held PRG accesses
		sprite_dma(1'b0);
		sprite_dma(1'b1);           // DMC fetch cuts into the transfer

		if (error_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "errors found");
		end
	end

endmodule

// ==== compile.f ====
+incdir+.
nes_bus_pkg.sv
clock_divider.sv
dma_controller.sv
memory_multiplex.sv
nes_bus_core.sv
tb_nes_bus_core.sv
